// File: dv/dcp_assertions.sv
`timescale 1ns/10ps

module dcp_assertions (
    input logic             clk,
    input logic             rstn,
    input logic             rx_rdy,
    input logic [7:0]       tx_data,
    input logic             tx_vld,
    input logic             tx_rdy,
    input dcp_pkg::wb_req_t wb_req,
    input dcp_pkg::wb_rsp_t wb_rsp
);

    // single-word access ends in the cycle after ack
    wb_drop: assert property (@(posedge clk) disable iff (!rstn)
        (wb_req.cyc && wb_rsp.ack) |=> (!wb_req.cyc && !wb_req.stb))
        else $error("wishbone cycle still open after ack");

    // whole request frozen until the slave acks
    wb_hold: assert property (@(posedge clk) disable iff (!rstn)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
        else $error("wishbone request changed before ack");

    tx_hold: assert property (@(posedge clk) disable iff (!rstn)
        (tx_vld && !tx_rdy) |=> (tx_vld && $stable(tx_data)))
        else $error("tx byte dropped or changed while stalled");

    reset_idle: assert property (@(posedge clk)
        !rstn |-> (!rx_rdy && !tx_vld && !wb_req.cyc))
        else $error("handshake outputs active during reset");

endmodule

bind dcp dcp_assertions u_assertions (
    .clk     (clk),
    .rstn    (rstn),
    .rx_rdy  (rx_rdy),
    .tx_data (tx_data),
    .tx_vld  (tx_vld),
    .tx_rdy  (tx_rdy),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
);

// File: dv/dcp_tb.sv
`timescale 1ns/10ps

module dcp_tb;

    localparam int QUIET_CYCLES = 24;   // window for stray output bytes
    localparam int MEM_WORDS    = 256;

    logic                          clk;
    logic                          rstn;
    logic [7:0]                    rx_data;
    logic                          rx_vld;
    logic                          rx_rdy;
    logic [7:0]                    tx_data;
    logic                          tx_vld;
    logic                          tx_rdy;
    dcp_pkg::wb_req_t              wb_req;
    dcp_pkg::wb_rsp_t              wb_rsp;
    logic [dcp_pkg::REG_IDX_W-1:0] rf_idx;
    dcp_pkg::word_t                rf_data;

    // command table with one entry per index
    string          tab_name [$];
    string          tab_in [$];
    string          tab_out [$];
    bit             tab_chk [$];
    int             tab_adr [$];
    dcp_pkg::word_t tab_val [$];

    dcp_pkg::word_t mem [MEM_WORDS];
    logic [31:0]    lfsr = 32'he658_dd12;
    logic [7:0]     rx_q [$];
    logic [7:0]     out_q [$];
    int             rx_gap = 0;
    bit             rx_taken = 1'b0;
    bit             wb_busy = 1'b0;
    int             wb_wait = 0;
    int             cycle_cnt = 0;
    int             cycle_limit = 0;

    dcp uut (
        .clk     (clk),
        .rstn    (rstn),
        .rx_data (rx_data),
        .rx_vld  (rx_vld),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_vld  (tx_vld),
        .tx_rdy  (tx_rdy),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rf_idx  (rf_idx),
        .rf_data (rf_data)
    );

    assign rf_data = reg_value(int'(rf_idx));   // same-cycle read port

    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    function automatic dcp_pkg::word_t preload_value(input int idx);
        return dcp_pkg::word_t'(idx) * 32'h0001_0003;
    endfunction

    function automatic dcp_pkg::word_t reg_value(input int idx);
        return dcp_pkg::word_t'(idx) ^ 32'hA5A5_0000;
    endfunction

    // 8 upper-case hex digits and a line feed
    function automatic string hex_line(input dcp_pkg::word_t w);
        string s;
        s = $sformatf("%08h", w);
        return {s.toupper(), "\n"};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("Error: %s expected 8'h%02h actual 8'h%02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input dcp_pkg::word_t exp,
                              input dcp_pkg::word_t act);
        if (act !== exp)
            stop_run($sformatf("Error: %s expected 32'h%08h actual 32'h%08h", name, exp, act));
    endtask

    task automatic add_entry(input string name, input string in_s, input string out_s,
                             input bit chk, input int adr, input dcp_pkg::word_t val);
        tab_name.push_back(name);
        tab_in.push_back(in_s);
        tab_out.push_back(out_s);
        tab_chk.push_back(chk);
        tab_adr.push_back(adr);
        tab_val.push_back(val);
    endtask

    task automatic load_table();
        string q;
        q = $sformatf("%c", dcp_pkg::CHAR_ERR);
        add_entry("write_e", "E 10 DEADBEEF\n", "", 1'b1, 'h10, 32'hDEAD_BEEF);
        add_entry("read_back", "D 10\n", hex_line(32'hDEAD_BEEF), 1'b1, 'h10, 32'hDEAD_BEEF);
        add_entry("read_preload", "D 7\n", hex_line(preload_value(7)), 1'b0, 0, '0);
        add_entry("reg_upper", "R 1F\n", hex_line(reg_value(31)), 1'b0, 0, '0);
        add_entry("reg_lower", "R 1f\n", hex_line(reg_value(31)), 1'b0, 0, '0);
        add_entry("reg_crlf", "R 0\015\n", hex_line(reg_value(0)), 1'b0, 0, '0);
        add_entry("blank_only", " \n  \015\n", "", 1'b0, 0, '0);
        add_entry("blank_lead", "  \n\n D 3\n", hex_line(preload_value(3)), 1'b0, 0, '0);
        add_entry("unknown_q", "Q\n", q, 1'b0, 0, '0);
        // bad digit ends the token so the leftover '5' is read as a letter
        add_entry("bad_hex", "E 2G 5\n", {q, q}, 1'b1, 2, preload_value(2));
        add_entry("after_bad", "D 2\n", hex_line(preload_value(2)), 1'b1, 2, preload_value(2));
        add_entry("mixed_case", "E fF 0123abCD\n", "", 1'b1, 'hFF, 32'h0123_ABCD);
        add_entry("read_ff", "D FF\n", hex_line(32'h0123_ABCD), 1'b0, 0, '0);
        add_entry("nine_digits", "D 100000012\n", hex_line(preload_value('h12)), 1'b0, 0, '0);
    endtask

    task automatic feed_rx();
        if (rx_taken) begin
            void'(rx_q.pop_front());
            rx_gap = random_bits(2);
        end
        if (rx_gap > 0) begin
            rx_vld = 1'b0;
            rx_gap--;
        end else if (rx_q.size() == 0) begin
            rx_vld = 1'b0;
        end else begin
            rx_vld  = 1'b1;
            rx_data = rx_q[0];
        end
        rx_taken = rx_vld && rx_rdy;   // rx_rdy is a flop output and stable here
    endtask

    task automatic collect_tx();
        tx_rdy = (random_bits(2) != 0);
        if (tx_vld && tx_rdy)
            out_q.push_back(tx_data);
    endtask

    task automatic serve_wishbone();
        int idx;
        idx        = int'(wb_req.adr[7:0]);
        wb_rsp.ack = 1'b0;
        wb_rsp.dat = '0;
        if (!(wb_req.cyc && wb_req.stb)) begin
            wb_busy = 1'b0;
        end else begin
            if (!wb_busy) begin
                wb_busy = 1'b1;
                wb_wait = random_bits(2);
            end
            if (wb_wait == 0) begin
                wb_rsp.ack = 1'b1;
                if (wb_req.we)
                    mem[idx] = wb_req.dat;
                else
                    wb_rsp.dat = mem[idx];
            end else begin
                wb_wait--;
            end
        end
    endtask

    task automatic apply_entry(input int n);
        string in_s;
        string exp_s;
        in_s  = tab_in[n];
        exp_s = tab_out[n];
        out_q.delete();
        for (int i = 0; i < in_s.len(); i++)
            rx_q.push_back(in_s[i]);
        while (rx_q.size() != 0 || out_q.size() < exp_s.len())
            @(posedge clk);
        repeat (QUIET_CYCLES) @(posedge clk);
        if (out_q.size() > exp_s.len())
            stop_run($sformatf("test %s sent %0d output bytes but only %0d were expected",
                               tab_name[n], out_q.size(), exp_s.len()));
        for (int i = 0; i < exp_s.len(); i++)
            check_char(tab_name[n], exp_s[i], out_q[i]);
        if (tab_chk[n])
            check_word(tab_name[n], tab_val[n], mem[tab_adr[n]]);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // input drivers and models run 1 ns after each rising edge
    initial begin
        rx_data = 8'h00;
        rx_vld  = 1'b0;
        tx_rdy  = 1'b0;
        wb_rsp  = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = preload_value(i);
        forever begin
            @(posedge clk);
            #1;
            feed_rx();
            collect_tx();
            serve_wishbone();
        end
    end

    initial begin
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        stop_run($sformatf("simulation timed out after %0d cycles", cycle_cnt));
    end

    initial begin
        rstn = 1'b0;
        load_table();
        cycle_limit = 200;
        for (int i = 0; i < tab_name.size(); i++)
            cycle_limit += 40 * (tab_in[i].len() + tab_out[i].len());
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        for (int i = 0; i < tab_name.size(); i++)
            apply_entry(i);
        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
hw/dcp_pkg.sv
hw/dcp_scan.sv
hw/dcp_print.sv
hw/dcp_mem_cmd.sv
hw/dcp_reg_cmd.sv
hw/dcp.sv
dv/dcp_assertions.sv
dv/dcp_tb.sv

// File: hw/dcp.sv
`timescale 1ns/10ps

module dcp (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [7:0]                    rx_data,
    input  logic                          rx_vld,
    output logic                          rx_rdy,
    output logic [7:0]                    tx_data,
    output logic                          tx_vld,
    input  logic                          tx_rdy,
    output dcp_pkg::wb_req_t              wb_req,
    input  dcp_pkg::wb_rsp_t              wb_rsp,
    output logic [dcp_pkg::REG_IDX_W-1:0] rf_idx,
    input  dcp_pkg::word_t                rf_data
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_LETTER,
        D_RUN,
        D_REJECT
    } state_e;

    state_e              state;
    dcp_pkg::cmd_e       cmd_q;
    logic                start_mem;
    logic                start_reg;
    logic                mem_done;
    logic                reg_done;
    logic                run_done;
    logic                print_ack;
    logic                is_space;
    logic [7:0]          letter;
    dcp_pkg::scan_req_t  scan_req;
    dcp_pkg::scan_req_t  mem_scan;
    dcp_pkg::scan_req_t  reg_scan;
    dcp_pkg::scan_rsp_t  scan_rsp;
    dcp_pkg::print_req_t print_req;
    dcp_pkg::print_req_t mem_print;
    dcp_pkg::print_req_t reg_print;

    assign letter   = scan_rsp.value[7:0];
    assign is_space = (letter == dcp_pkg::CHAR_SPACE) || (letter == dcp_pkg::CHAR_CR) ||
                      (letter == dcp_pkg::CHAR_LF);
    assign run_done = (cmd_q == dcp_pkg::CMD_R) ? reg_done : mem_done;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= D_IDLE;
            cmd_q     <= dcp_pkg::CMD_D;
            start_mem <= 1'b0;
            start_reg <= 1'b0;
        end else begin
            start_mem <= 1'b0;
            start_reg <= 1'b0;
            case (state)
                D_IDLE: state <= D_LETTER;
                D_LETTER: begin
                    // whitespace keeps us here for the next byte
                    if (scan_rsp.ack && !is_space) begin
                        case (letter)
                            dcp_pkg::CMD_D, dcp_pkg::CMD_E: begin
                                start_mem <= 1'b1;
                                cmd_q     <= dcp_pkg::cmd_e'(letter);
                                state     <= D_RUN;
                            end
                            dcp_pkg::CMD_R: begin
                                start_reg <= 1'b1;
                                cmd_q     <= dcp_pkg::CMD_R;
                                state     <= D_RUN;
                            end
                            default: state <= D_REJECT;
                        endcase
                    end
                end
                D_RUN:    if (run_done) state <= D_IDLE;
                default:  if (print_ack) state <= D_IDLE;  // reject
            endcase
        end
    end

    // route the shared reader and writer
    always_comb begin
        scan_req  = '0;
        print_req = '0;
        case (state)
            D_LETTER: scan_req = '{req: 1'b1, kind: dcp_pkg::TOK_CHAR};
            D_REJECT: print_req = '{req: 1'b1, kind: dcp_pkg::TOK_CHAR,
                                    value: {24'h0, dcp_pkg::CHAR_ERR}};
            D_RUN: begin
                if (cmd_q == dcp_pkg::CMD_R) begin
                    scan_req  = reg_scan;
                    print_req = reg_print;
                end else begin
                    scan_req  = mem_scan;
                    print_req = mem_print;
                end
            end
            default: ;
        endcase
    end

    dcp_scan u_scan (
        .clk      (clk),
        .rstn     (rstn),
        .rx_data  (rx_data),
        .rx_vld   (rx_vld),
        .rx_rdy   (rx_rdy),
        .scan_req (scan_req),
        .scan_rsp (scan_rsp)
    );

    dcp_print u_print (
        .clk       (clk),
        .rstn      (rstn),
        .print_req (print_req),
        .print_ack (print_ack),
        .tx_data   (tx_data),
        .tx_vld    (tx_vld),
        .tx_rdy    (tx_rdy)
    );

    dcp_mem_cmd u_mem (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start_mem),
        .cmd       (cmd_q),
        .done      (mem_done),
        .scan_req  (mem_scan),
        .scan_rsp  (scan_rsp),
        .print_req (mem_print),
        .print_ack (print_ack),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    dcp_reg_cmd u_reg (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start_reg),
        .done      (reg_done),
        .scan_req  (reg_scan),
        .scan_rsp  (scan_rsp),
        .print_req (reg_print),
        .print_ack (print_ack),
        .rf_idx    (rf_idx),
        .rf_data   (rf_data)
    );

endmodule

// File: hw/dcp_mem_cmd.sv
`timescale 1ns/10ps

module dcp_mem_cmd (
    input  logic                clk,
    input  logic                rstn,
    input  logic                start,
    input  dcp_pkg::cmd_e       cmd,
    output logic                done,
    output dcp_pkg::scan_req_t  scan_req,
    input  dcp_pkg::scan_rsp_t  scan_rsp,
    output dcp_pkg::print_req_t print_req,
    input  logic                print_ack,
    output dcp_pkg::wb_req_t    wb_req,
    input  dcp_pkg::wb_rsp_t    wb_rsp
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_ADDR,
        M_DATA,
        M_BUS,
        M_PRINT,
        M_DONE
    } state_e;

    state_e             state;
    logic               write_q;   // E command
    logic               got;
    dcp_pkg::word_t     adr_q;
    dcp_pkg::word_t     dat_q;
    dcp_pkg::word_t     out_q;
    dcp_pkg::tok_kind_e out_kind;

    assign got  = scan_rsp.ack && scan_req.req;
    assign done = (state == M_DONE);

    assign scan_req  = '{req:  (state == M_ADDR) || (state == M_DATA),
                         kind: dcp_pkg::TOK_WORD};
    assign print_req = '{req: (state == M_PRINT), kind: out_kind, value: out_q};
    assign wb_req    = '{cyc: (state == M_BUS), stb: (state == M_BUS),
                         we: write_q, adr: adr_q, dat: dat_q};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= M_IDLE;
            write_q <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (start) begin
                        write_q <= (cmd == dcp_pkg::CMD_E);
                        state   <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    if (got) begin
                        if (scan_rsp.err)
                            state <= M_PRINT;
                        else if (write_q)
                            state <= M_DATA;
                        else
                            state <= M_BUS;
                    end
                end
                M_DATA: begin
                    if (got)
                        state <= scan_rsp.err ? M_PRINT : M_BUS;
                end
                M_BUS: begin
                    // cyc and stb drop the cycle after ack
                    if (wb_rsp.ack)
                        state <= write_q ? M_DONE : M_PRINT;
                end
                M_PRINT: begin
                    if (print_ack)
                        state <= M_DONE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (got && state == M_ADDR)
            adr_q <= scan_rsp.value;
        if (got && state == M_DATA)
            dat_q <= scan_rsp.value;
        if (got && scan_rsp.err) begin
            out_kind <= dcp_pkg::TOK_CHAR;
            out_q    <= {24'h0, dcp_pkg::CHAR_ERR};
        end else if (state == M_BUS && wb_rsp.ack) begin
            out_kind <= dcp_pkg::TOK_WORD;
            out_q    <= wb_rsp.dat;
        end
    end

endmodule

// File: hw/dcp_pkg.sv
package dcp_pkg;

    typedef logic [31:0] word_t;

    // what a scan or print request carries
    typedef enum logic {
        TOK_CHAR = 1'b0,
        TOK_WORD = 1'b1
    } tok_kind_e;

    // ascii command letters
    typedef enum logic [7:0] {
        CMD_D = 8'h44,
        CMD_E = 8'h45,
        CMD_R = 8'h52
    } cmd_e;

    typedef struct packed {
        logic      req;
        tok_kind_e kind;
    } scan_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;    // bad hex digit seen
        word_t value;
    } scan_rsp_t;

    typedef struct packed {
        logic      req;
        tok_kind_e kind;
        word_t     value;
    } print_req_t;

    // wishbone classic master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    localparam logic [7:0] CHAR_LF    = 8'h0A;
    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_SPACE = 8'h20;
    localparam logic [7:0] CHAR_ERR   = 8'h3F;   // '?'

    localparam int REG_IDX_W = 5;

endpackage

// File: hw/dcp_print.sv
`timescale 1ns/10ps

module dcp_print (
    input  logic                clk,
    input  logic                rstn,
    input  dcp_pkg::print_req_t print_req,
    output logic                print_ack,
    output logic [7:0]          tx_data,
    output logic                tx_vld,
    input  logic                tx_rdy
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_SEND,
        P_ACK
    } state_e;

    state_e             state;
    dcp_pkg::word_t     val;      // shifted left one digit per byte sent
    dcp_pkg::tok_kind_e kind_q;
    logic [3:0]         cnt;
    logic               last;

    assign last      = (kind_q == dcp_pkg::TOK_CHAR) || (cnt == 4'd8);
    assign tx_vld    = (state == P_SEND);
    assign print_ack = (state == P_ACK);

    always_comb begin
        if (kind_q == dcp_pkg::TOK_CHAR)
            tx_data = val[7:0];
        else if (cnt == 4'd8)
            tx_data = dcp_pkg::CHAR_LF;
        else if (val[31:28] < 4'd10)
            tx_data = {4'h3, val[31:28]};
        else
            tx_data = 8'h37 + {4'h0, val[31:28]};  // upper case A..F
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= P_IDLE;
            cnt   <= 4'd0;
        end else begin
            case (state)
                P_IDLE: begin
                    cnt <= 4'd0;
                    if (print_req.req)
                        state <= P_SEND;
                end
                P_SEND: begin
                    if (tx_rdy) begin
                        if (last)
                            state <= P_ACK;
                        else
                            cnt <= cnt + 4'd1;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_IDLE && print_req.req) begin
            val    <= print_req.value;
            kind_q <= print_req.kind;
        end else if (tx_vld && tx_rdy) begin
            val <= {val[27:0], 4'h0};
        end
    end

endmodule

// File: hw/dcp_reg_cmd.sv
`timescale 1ns/10ps

module dcp_reg_cmd (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          start,
    output logic                          done,
    output dcp_pkg::scan_req_t            scan_req,
    input  dcp_pkg::scan_rsp_t            scan_rsp,
    output dcp_pkg::print_req_t           print_req,
    input  logic                          print_ack,
    output logic [dcp_pkg::REG_IDX_W-1:0] rf_idx,
    input  dcp_pkg::word_t                rf_data
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_IDX,
        R_PRINT,
        R_DONE
    } state_e;

    state_e             state;
    logic               got;
    dcp_pkg::word_t     out_q;
    dcp_pkg::tok_kind_e out_kind;

    assign got       = scan_rsp.ack && scan_req.req;
    assign done      = (state == R_DONE);
    assign rf_idx    = scan_rsp.value[dcp_pkg::REG_IDX_W-1:0];  // upper bits ignored
    assign scan_req  = '{req: (state == R_IDX), kind: dcp_pkg::TOK_WORD};
    assign print_req = '{req: (state == R_PRINT), kind: out_kind, value: out_q};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= R_IDLE;
        end else begin
            case (state)
                R_IDLE:  if (start) state <= R_IDX;
                R_IDX:   if (got) state <= R_PRINT;
                R_PRINT: if (print_ack) state <= R_DONE;
                default: state <= R_IDLE;
            endcase
        end
    end

    // register file port is combinational, so capture on the same ack
    always_ff @(posedge clk) begin
        if (got) begin
            out_kind <= scan_rsp.err ? dcp_pkg::TOK_CHAR : dcp_pkg::TOK_WORD;
            out_q    <= scan_rsp.err ? {24'h0, dcp_pkg::CHAR_ERR} : rf_data;
        end
    end

endmodule

// File: hw/dcp_scan.sv
`timescale 1ns/10ps

module dcp_scan (
    input  logic               clk,
    input  logic               rstn,
    input  logic [7:0]         rx_data,
    input  logic               rx_vld,
    output logic               rx_rdy,
    input  dcp_pkg::scan_req_t scan_req,
    output dcp_pkg::scan_rsp_t scan_rsp
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RECV,
        S_ACK
    } state_e;

    state_e         state;
    dcp_pkg::word_t acc;
    logic           err_q;
    logic           have_digit;
    logic [4:0]     hex;        // bit 4 marks a valid digit
    logic           is_sep;
    logic           tok_end;

    function automatic logic [4:0] hex_val(input logic [7:0] c);
        logic [4:0] r;
        r = 5'h00;
        if (c >= 8'h30 && c <= 8'h39) begin
            r = {1'b1, c[3:0]};
        end else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66)) begin
            r = {1'b1, c[3:0] + 4'd9};  // same low nibble for both cases
        end
        return r;
    endfunction

    assign hex    = hex_val(rx_data);
    assign is_sep = (rx_data == dcp_pkg::CHAR_SPACE) || (rx_data == dcp_pkg::CHAR_CR) ||
                    (rx_data == dcp_pkg::CHAR_LF);
    assign rx_rdy = (state == S_RECV);

    // separators before the first digit are skipped
    assign tok_end = rx_vld && ((scan_req.kind == dcp_pkg::TOK_CHAR) ||
                                (!hex[4] && (have_digit || !is_sep)));

    assign scan_rsp = '{ack: (state == S_ACK), err: err_q, value: acc};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= S_IDLE;
            err_q      <= 1'b0;
            have_digit <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    err_q      <= 1'b0;
                    have_digit <= 1'b0;
                    if (scan_req.req)
                        state <= S_RECV;
                end
                S_RECV: begin
                    if (rx_vld && scan_req.kind == dcp_pkg::TOK_WORD) begin
                        if (hex[4])
                            have_digit <= 1'b1;
                        else if (!is_sep)
                            err_q <= 1'b1;
                    end
                    if (tok_end)
                        state <= S_ACK;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            acc <= '0;
        end else if (rx_rdy && rx_vld) begin
            if (scan_req.kind == dcp_pkg::TOK_CHAR)
                acc <= {24'h0, rx_data};
            else if (hex[4])
                acc <= {acc[27:0], hex[3:0]};  // keeps the last 8 digits
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the dcp testbench with verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module dcp_tb -f flist.f -o dcp_sim \
    && ./obj_dir/dcp_sim > sim.log 2>&1 \
    || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1
exit 0
